// ==== src/sparserPkg.sv ====
// Shared widths, lengths and transaction kinds of the parallel to serial bridge
package sparserPkg;

        // Serial data word and parallel data bus
        localparam int WordW = 32;
        localparam int ByteW = 8;
        localparam int DataBytes = 4;

        // Bit counter and last-bit index width
        localparam int CntW = 5;

        // An address write always sends four bits
        localparam logic [CntW-1:0] AddrLastBit = 5'd3;

        // Host strobes, index 0 is the strobe and index 1 is autofeed
        localparam int StrobeLines = 2;

        // Equal samples needed before a debounced level moves
        localparam int DebounceLen = 3;

        // Transaction kinds handed from the parser to the serial engine
        typedef enum logic [1:0] {
                OpWrAddr = 2'd0,
                OpWrData = 2'd1,
                OpRdData = 2'd2
        } opKindT;

endpackage

// ==== src/strobeDebounce.sv ====
module strobeDebounce (
        input  logic ICK,
        input  logic RST,
        input  logic raw,
        output logic level
);

        logic [1:0] syncQ;
        logic [$clog2(sparserPkg::DebounceLen + 1)-1:0] stableCnt;

        // Two-flop synchronizer, idle level of the strobe is high
        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        syncQ <= 2'b11;
                end else begin
                        syncQ <= {syncQ[0], raw};
                end
        end

        // Count samples that differ from the current level and
        // move the level once enough of them arrived in a row
        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        stableCnt <= '0;
                        level <= 1'b1;
                end else if (syncQ[1] == level) begin
                        stableCnt <= '0;
                end else if (int'(stableCnt) == sparserPkg::DebounceLen - 1) begin
                        stableCnt <= '0;
                        level <= syncQ[1];
                end else begin
                        stableCnt <= stableCnt + 1'b1;
                end
        end

endmodule

// ==== src/portParser.sv ====
module portParser (
        input  logic                               ICK,
        input  logic                               RST,
        input  logic                               nStb,
        input  logic                               nAufd,
        input  logic [sparserPkg::ByteW-1:0]       ppdIn,
        output logic [sparserPkg::ByteW-1:0]       ppdOut,
        output logic                               ppdOe,
        output logic                               busy,
        output logic                               launch,
        output sparserPkg::opKindT                 opKind,
        output logic [sparserPkg::WordW-1:0]       txWord,
        output logic [sparserPkg::CntW-1:0]        lastBit,
        input  logic [sparserPkg::WordW-1:0]       rxWord,
        input  logic                               done
);

        typedef enum logic [3:0] {
                StIdle      = 4'h0,
                StCmdWait   = 4'h1,
                StCmdHold   = 4'h2,
                StAddrWait  = 4'h3,
                StDataWait  = 4'h4,
                StDataLatch = 4'h5,
                StWrRun     = 4'h6,
                StRdRun     = 4'h7,
                StRdWait    = 4'h8,
                StRdShow    = 4'h9
        } stateT;

        stateT state;
        stateT nextState;

        logic [sparserPkg::ByteW-1:0] cmd;
        logic [sparserPkg::DataBytes-1:0][sparserPkg::ByteW-1:0] wrBytes;
        logic [sparserPkg::DataBytes-1:0][sparserPkg::ByteW-1:0] rxBytes;
        logic [$clog2(sparserPkg::DataBytes)-1:0] wrCnt;
        logic [$clog2(sparserPkg::DataBytes)-1:0] rdCnt;
        logic cmdStart;
        logic byteSave;
        logic byteNext;
        logic goRun;

        // Command decode, the top two bits pick the transaction
        always_comb begin
                case (cmd[7:6])
                        2'b10:   opKind = sparserPkg::OpWrData;
                        2'b11:   opKind = sparserPkg::OpRdData;
                        default: opKind = sparserPkg::OpWrAddr;
                endcase
        end

        always_comb begin
                nextState = state;
                case (state)
                        StIdle:      if (!nStb) nextState = StCmdWait;
                        StCmdWait:   if (!nAufd) nextState = StCmdHold;
                        StCmdHold: begin
                                if (nAufd) begin
                                        case (opKind)
                                                sparserPkg::OpWrData: nextState = StDataWait;
                                                sparserPkg::OpRdData: nextState = StRdRun;
                                                default:              nextState = StAddrWait;
                                        endcase
                                end
                        end
                        StAddrWait:  if (nStb) nextState = StWrRun;
                        StDataWait: begin
                                if (nStb) begin
                                        nextState = StWrRun;
                                end else if (!nAufd) begin
                                        nextState = StDataLatch;
                                end
                        end
                        StDataLatch: if (nAufd) nextState = StDataWait;
                        StWrRun:     if (done) nextState = StIdle;
                        StRdRun:     if (done) nextState = StRdWait;
                        StRdWait: begin
                                if (nStb) begin
                                        nextState = StIdle;
                                end else if (!nAufd) begin
                                        nextState = StRdShow;
                                end
                        end
                        StRdShow:    if (nAufd) nextState = StRdWait;
                        default:     nextState = StIdle;
                endcase
        end

        assign cmdStart = (state == StCmdWait) && (nextState == StCmdHold);
        assign byteSave = (state == StDataWait) && (nextState == StDataLatch);
        assign byteNext = (state == StRdShow) && (nextState == StRdWait);
        assign goRun = (nextState != state) &&
                       ((nextState == StWrRun) || (nextState == StRdRun));

        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        state <= StIdle;
                        launch <= 1'b0;
                        busy <= 1'b0;
                end else begin
                        state <= nextState;
                        launch <= goRun;
                        // Busy follows the state being entered
                        if ((nextState == StCmdWait) || (nextState == StRdShow)) begin
                                busy <= 1'b1;
                        end else if ((nextState == StIdle) || (nextState == StRdWait)) begin
                                busy <= 1'b0;
                        end
                end
        end

        // Byte counters restart with every command
        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        wrCnt <= '0;
                        rdCnt <= '0;
                end else if (cmdStart) begin
                        wrCnt <= '0;
                        rdCnt <= '0;
                end else begin
                        if (byteSave) wrCnt <= wrCnt + 1'b1;
                        if (byteNext) rdCnt <= rdCnt + 1'b1;
                end
        end

        always_ff @(posedge ICK) begin
                if (cmdStart) begin
                        cmd <= ppdIn;
                end
        end

        // Bytes that the host does not send stay zero
        always_ff @(posedge ICK) begin
                if (cmdStart) begin
                        wrBytes <= '0;
                end else if (byteSave) begin
                        wrBytes[wrCnt] <= ppdIn;
                end
        end

        assign txWord = (opKind == sparserPkg::OpWrAddr) ?
                        {{(sparserPkg::WordW - 4){1'b0}}, cmd[3:0]} : wrBytes;
        assign lastBit = (opKind == sparserPkg::OpWrAddr) ?
                         sparserPkg::AddrLastBit : cmd[sparserPkg::CntW-1:0];

        // Read result goes out lowest byte first
        assign rxBytes = rxWord;
        assign ppdOut = rxBytes[rdCnt];
        assign ppdOe = (state == StRdShow);

        oeWithinBusy: assert property (@(posedge ICK) disable iff (RST) ppdOe |-> busy)
                else $error("ppdOe is high while busy is low");

        launchSingle: assert property (@(posedge ICK) disable iff (RST) launch |=> !launch)
                else $error("launch held for more than one cycle");

endmodule

// ==== src/serialEngine.sv ====
module serialEngine (
        input  logic                          ICK,
        input  logic                          RST,
        input  logic                          launch,
        input  sparserPkg::opKindT            opKind,
        input  logic [sparserPkg::WordW-1:0]  txWord,
        input  logic [sparserPkg::CntW-1:0]   lastBit,
        output logic [sparserPkg::WordW-1:0]  rxWord,
        output logic                          done,
        output logic                          ims,
        output logic                          idOut,
        input  logic                          idIn,
        output logic                          idOe
);

        sparserPkg::opKindT kindQ;
        logic [sparserPkg::WordW-1:0] txQ;
        logic [sparserPkg::CntW-1:0] lastQ;
        logic [sparserPkg::CntW-1:0] bitCnt;
        logic finish;
        logic endQ;

        // Last bit of the transfer is on the line in this cycle
        assign finish = !ims && (bitCnt == lastQ);

        // The select stays low for lastBit plus 1 cycles, then done
        // follows one cycle after the select is back high
        always_ff @(posedge ICK or posedge RST) begin
                if (RST) begin
                        ims <= 1'b1;
                        bitCnt <= '0;
                        lastQ <= '0;
                        kindQ <= sparserPkg::OpWrAddr;
                        endQ <= 1'b0;
                        done <= 1'b0;
                end else begin
                        endQ <= finish;
                        done <= endQ;
                        if (launch) begin
                                ims <= 1'b0;
                                bitCnt <= '0;
                                lastQ <= lastBit;
                                kindQ <= opKind;
                        end else if (finish) begin
                                ims <= 1'b1;
                        end else if (!ims) begin
                                bitCnt <= bitCnt + 1'b1;
                        end
                end
        end

        always_ff @(posedge ICK) begin
                if (launch) begin
                        txQ <= txWord;
                end
        end

        // Write bits leave on the falling edge with bit 0 first
        always_ff @(negedge ICK) begin
                idOut <= txQ[bitCnt];
        end

        assign idOe = !ims && (kindQ != sparserPkg::OpRdData);

        // The chip sends its top bit first, so shifting in from the
        // low end leaves the word in its natural order
        always_ff @(posedge ICK) begin
                if (launch) begin
                        rxWord <= '0;
                end else if (!ims && (kindQ == sparserPkg::OpRdData)) begin
                        rxWord <= {rxWord[sparserPkg::WordW-2:0], idIn};
                end
        end

        launchWhenIdle: assert property (@(posedge ICK) disable iff (RST) launch |-> ims)
                else $error("launch arrived during a serial transfer");

        noDriveOnRead: assert property (@(posedge ICK) disable iff (RST)
                (launch && (opKind == sparserPkg::OpRdData)) |=> !idOe)
                else $error("serial line driven during a read");

endmodule

// ==== src/sparserTop.sv ====
module sparserTop (
        input  logic                          ICK,
        input  logic                          RST,
        input  logic                          nStbRaw,
        input  logic                          nAufdRaw,
        input  logic [sparserPkg::ByteW-1:0]  ppdIn,
        output logic [sparserPkg::ByteW-1:0]  ppdOut,
        output logic                          ppdOe,
        output logic                          busy,
        output logic                          ims,
        input  logic                          idIn,
        output logic                          idOut,
        output logic                          idOe
);

        logic [sparserPkg::StrobeLines-1:0] rawLines;
        logic [sparserPkg::StrobeLines-1:0] lineLevel;
        logic launch;
        sparserPkg::opKindT opKind;
        logic [sparserPkg::WordW-1:0] txWord;
        logic [sparserPkg::CntW-1:0] lastBit;
        logic [sparserPkg::WordW-1:0] rxWord;
        logic done;

        // Index 0 is the strobe, index 1 is autofeed
        assign rawLines = {nAufdRaw, nStbRaw};

        for (genvar i = 0; i < sparserPkg::StrobeLines; i++) begin : gDebounce
                strobeDebounce u_strobeDebounce (
                        .ICK   (ICK),
                        .RST   (RST),
                        .raw   (rawLines[i]),
                        .level (lineLevel[i])
                );
        end

        portParser u_portParser (
                .ICK     (ICK),
                .RST     (RST),
                .nStb    (lineLevel[0]),
                .nAufd   (lineLevel[1]),
                .ppdIn   (ppdIn),
                .ppdOut  (ppdOut),
                .ppdOe   (ppdOe),
                .busy    (busy),
                .launch  (launch),
                .opKind  (opKind),
                .txWord  (txWord),
                .lastBit (lastBit),
                .rxWord  (rxWord),
                .done    (done)
        );

        serialEngine u_serialEngine (
                .ICK     (ICK),
                .RST     (RST),
                .launch  (launch),
                .opKind  (opKind),
                .txWord  (txWord),
                .lastBit (lastBit),
                .rxWord  (rxWord),
                .done    (done),
                .ims     (ims),
                .idOut   (idOut),
                .idIn    (idIn),
                .idOe    (idOe)
        );

endmodule

// ==== testbench/tbSerialSlave.sv ====
module tbSerialSlave (
        input  logic                         ICK,
        input  logic                         ims,
        input  logic                         idOut,
        input  logic                         idOe,
        output logic                         idIn,
        input  logic                         addrMode,
        input  logic [sparserPkg::CntW-1:0]  rdLast
);

        timeunit 1ns;
        timeprecision 100ps;

        logic [sparserPkg::WordW-1:0] regs [16];
        logic [3:0] addrReg = '0;
        logic [sparserPkg::WordW-1:0] shiftQ = '0;
        logic [sparserPkg::WordW-1:0] bitCount = '0;
        logic [sparserPkg::WordW-1:0] lastCount = '0;
        logic wasWrite = 1'b0;
        logic [sparserPkg::CntW-1:0] rdIdx = '0;

        // Power-up contents differ in every register
        initial begin
                for (int i = 0; i < 16; i++) begin
                        regs[i] = 32'h9e37_79b9 * (i + 1);
                end
        end

        // Write bits arrive lowest first while the select is low.
        // addrMode tells the model that a write targets the address register
        always @(posedge ICK) begin
                if (!ims) begin
                        wasWrite = idOe;
                        if (idOe) begin
                                shiftQ[bitCount[4:0]] = idOut;
                        end
                        bitCount = bitCount + 1;
                end else if (bitCount != 0) begin
                        lastCount = bitCount;
                        bitCount = '0;
                        if (wasWrite && addrMode) begin
                                addrReg = shiftQ[3:0];
                        end else if (wasWrite) begin
                                regs[addrReg] = shiftQ;
                        end
                        shiftQ = '0;
                end
        end

        // Read bits go out top first, one per cycle after the first sample
        always @(negedge ICK) begin
                if (ims) begin
                        rdIdx = rdLast;
                end else if (bitCount != 0) begin
                        rdIdx = rdIdx - 1'b1;
                end
        end

        assign idIn = ims ? 1'b0 : regs[addrReg][rdIdx];

endmodule

// ==== testbench/tbSparser.sv ====
module tbSparser;

        timeunit 1ns;
        timeprecision 100ps;

        // One host step outlasts the worst debounce latency
        localparam int StepCycles = sparserPkg::DebounceLen + 4;
        localparam int BusyLimit = 64;
        localparam int RandomRuns = 8;
        localparam int NumTests = 5 + RandomRuns;
        localparam int StepsPerTest = 60;
        localparam int WatchdogNs = NumTests * StepsPerTest * StepCycles * 10 * 2;

        logic ICK = 1'b0;
        logic RST;
        logic nStbRaw;
        logic nAufdRaw;
        logic [sparserPkg::ByteW-1:0] ppdIn;
        logic [sparserPkg::ByteW-1:0] ppdOut;
        logic ppdOe;
        logic busy;
        logic ims;
        logic idIn;
        logic idOut;
        logic idOe;
        logic addrMode;
        logic [sparserPkg::CntW-1:0] rdLast;
        logic [sparserPkg::WordW-1:0] refRegs [16];
        logic [3:0] curAddr;
        logic [31:0] rngState;
        logic fetchPhase;
        string testName;

        sparserTop u_sparserTop (.*);

        tbSerialSlave u_serialSlave (.*);

        always #5 ICK = ~ICK;

        task automatic failRun(input string what);
                $display("%s", what);
                $display("TEST FAILED");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic checkWord(input string what, input logic [sparserPkg::WordW-1:0] expected,
                                 input logic [sparserPkg::WordW-1:0] actual);
                if (actual !== expected) begin
                        failRun($sformatf("mismatch in %s, %s: expected %h, actual %h",
                                          testName, what, expected, actual));
                end
        endtask

        task automatic checkBit(input string what, input logic expected, input logic actual);
                if (actual !== expected) begin
                        failRun($sformatf("mismatch in %s, %s: expected %b, actual %b",
                                          testName, what, expected, actual));
                end
        endtask

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] x;
                x = s;
                x ^= x << 13;
                x ^= x >> 17;
                x ^= x << 5;
                return x;
        endfunction

        function automatic logic [sparserPkg::WordW-1:0] lowBits(
                        input logic [sparserPkg::CntW-1:0] last);
                return {sparserPkg::WordW{1'b1}} >> (sparserPkg::WordW - 1 - int'(last));
        endfunction

        task automatic hostStep(input logic stb, input logic aufd);
                nStbRaw = stb;
                nAufdRaw = aufd;
                repeat (StepCycles) @(negedge ICK);
        endtask

        task automatic waitBusyLow(input string what);
                int n;
                n = 0;
                while ((busy !== 1'b0) && (n < BusyLimit)) begin
                        @(negedge ICK);
                        n++;
                end
                if (busy !== 1'b0) begin
                        failRun($sformatf("busy stayed high for %0d cycles in %s of %s",
                                          BusyLimit, what, testName));
                end
        endtask

        task automatic setAddress(input logic [3:0] addr);
                addrMode = 1'b1;
                curAddr = addr;
                ppdIn = {4'b0000, addr};
                hostStep(1'b0, 1'b1);
                hostStep(1'b0, 1'b0);
                hostStep(1'b0, 1'b1);
                nStbRaw = 1'b1;
                waitBusyLow("setAddress");
                checkWord("address bit count", 32'd4, u_serialSlave.lastCount);
                checkWord("address register", {28'd0, addr}, {28'd0, u_serialSlave.addrReg});
        endtask

        // Bytes that are not sent must read back as zero
        task automatic writeWord(input logic [sparserPkg::WordW-1:0] data, input int nBytes,
                                 input logic [sparserPkg::CntW-1:0] last);
                logic [sparserPkg::WordW-1:0] expected;
                addrMode = 1'b0;
                expected = '0;
                ppdIn = {3'b100, last};
                hostStep(1'b0, 1'b1);
                hostStep(1'b0, 1'b0);
                hostStep(1'b0, 1'b1);
                for (int b = 0; b < nBytes; b++) begin
                        ppdIn = data[8*b +: 8];
                        expected[8*b +: 8] = data[8*b +: 8];
                        hostStep(1'b0, 1'b0);
                        hostStep(1'b0, 1'b1);
                end
                nStbRaw = 1'b1;
                waitBusyLow("writeWord");
                expected = expected & lowBits(last);
                checkWord("data bit count", {27'd0, last} + 32'd1, u_serialSlave.lastCount);
                checkWord("written register", expected, u_serialSlave.regs[curAddr]);
                refRegs[curAddr] = expected;
        endtask

        task automatic readWord(input logic [sparserPkg::CntW-1:0] last);
                logic [sparserPkg::WordW-1:0] result;
                result = '0;
                rdLast = last;
                ppdIn = {3'b110, last};
                hostStep(1'b0, 1'b1);
                hostStep(1'b0, 1'b0);
                nAufdRaw = 1'b1;
                waitBusyLow("readWord");
                checkWord("read bit count", {27'd0, last} + 32'd1, u_serialSlave.lastCount);
                fetchPhase = 1'b1;
                for (int k = 0; k < sparserPkg::DataBytes; k++) begin
                        hostStep(1'b0, 1'b0);
                        checkBit("ppdOe while autofeed is low", 1'b1, ppdOe);
                        result[8*k +: 8] = ppdOut;
                        hostStep(1'b0, 1'b1);
                        checkBit("ppdOe after autofeed rose", 1'b0, ppdOe);
                end
                fetchPhase = 1'b0;
                hostStep(1'b1, 1'b1);
                checkBit("busy back in idle", 1'b0, busy);
                checkWord("read result", refRegs[curAddr] & lowBits(last), result);
        endtask

        // During the fetch busy follows ppdOe cycle by cycle
        always @(negedge ICK) begin
                if (fetchPhase && (busy !== ppdOe)) begin
                        failRun($sformatf("busy and ppdOe disagree during the fetch in %s",
                                          testName));
                end
        end

        task automatic resetLevels();
                testName = "reset levels";
                checkBit("busy", 1'b0, busy);
                checkBit("ppdOe", 1'b0, ppdOe);
                checkBit("idOe", 1'b0, idOe);
                checkBit("ims", 1'b1, ims);
        endtask

        task automatic addressWrites();
                testName = "address write";
                setAddress(4'ha);
                setAddress(4'h3);
        endtask

        task automatic fullWrites();
                testName = "four byte write";
                setAddress(4'h5);
                writeWord(32'hc3a5_1e7d, 4, 5'd19);
                setAddress(4'hc);
                writeWord(32'hd6e1_4b92, 4, 5'd31);
        endtask

        task automatic shortWrites();
                testName = "short write";
                setAddress(4'h6);
                writeWord(32'hffff_ffff, 2, 5'd31);
                writeWord(32'h1234_5678, 1, 5'd27);
        endtask

        task automatic readBacks();
                testName = "read back";
                setAddress(4'h5);
                readWord(5'd31);
                readWord(5'd10);
                setAddress(4'h9);
                readWord(5'd31);
        endtask

        task automatic randomSequences();
                logic [3:0] addr;
                logic [sparserPkg::CntW-1:0] last;
                int nBytes;
                testName = "random sequence";
                for (int i = 0; i < RandomRuns; i++) begin
                        rngState = xorshift(rngState);
                        addr = rngState[3:0];
                        last = rngState[8:4];
                        nBytes = 1 + int'(rngState[10:9]);
                        setAddress(addr);
                        rngState = xorshift(rngState);
                        writeWord(rngState, nBytes, last);
                        rngState = xorshift(rngState);
                        readWord(rngState[4:0]);
                end
        endtask

        initial begin
                RST = 1'b1;
                nStbRaw = 1'b1;
                nAufdRaw = 1'b1;
                ppdIn = '0;
                addrMode = 1'b0;
                rdLast = '0;
                curAddr = '0;
                fetchPhase = 1'b0;
                rngState = 32'he652;
                testName = "startup";
                repeat (2) @(posedge ICK);
                @(negedge ICK);
                RST = 1'b0;
                for (int i = 0; i < 16; i++) begin
                        refRegs[i] = u_serialSlave.regs[i];
                end
                resetLevels();
                addressWrites();
                fullWrites();
                shortWrites();
                readBacks();
                randomSequences();
                $display("TEST PASSED");
                $finish;
        end

        initial begin
                #(WatchdogNs);
                failRun("watchdog expired before all tests completed");
        end

endmodule

// ==== filelist.f ====
src/sparserPkg.sv
src/strobeDebounce.sv
src/portParser.sv
src/serialEngine.sv
src/sparserTop.sv
testbench/tbSerialSlave.sv
testbench/tbSparser.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tbSparser
FILELIST  := filelist.f
OBJDIR    := obj_dir
COMMON    := --timing --assert --timescale 1ns/100ps --top-module $(TOP)
LINTFLAGS := --lint-only $(COMMON)
SIMFLAGS  := --binary $(COMMON) --Mdir $(OBJDIR)

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

build:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST)

# The run counts as passed only when the pass line shows up in its output
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
